//--- source/core101_macros.svh
//--------------------------------------------------------------------------
// core101 shared macros
// Datapath widths, register count, reset PC, PC step and bubble word
//--------------------------------------------------------------------------
`ifndef CORE101_MACROS_SVH
`define CORE101_MACROS_SVH

// Datapath
`define XLEN        32              // Data and address width
`define REG_ADDR_W  5               // Register index width
`define REG_COUNT   32              // GPR count, x0 included

// Fetch
`define RESET_PC    32'h0000_0000   // First fetch address
`define PC_STEP     32'd4           // One 32-bit word per fetch

// ADDI x0,x0,0
`define INSTR_NOP   32'h0000_0013   // Bubble word inserted on halt

`endif

//--- source/core101_pkg.sv
//--------------------------------------------------------------------------
// core101 package
// Major opcode and ALU operation encodings used by decode and execute
//--------------------------------------------------------------------------
package core101_pkg;

  //------------------------------------------------------------------------
  // Major opcodes, bits [6:0] of the instruction word
  //------------------------------------------------------------------------
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,          // Register-register ALU
    OPC_OP_IMM = 7'b0010011,          // Register-immediate ALU
    OPC_LUI    = 7'b0110111           // Load upper immediate
  } opcode_e;                         // Anything else is a bubble

  //------------------------------------------------------------------------
  // ALU operations issued to execute
  //------------------------------------------------------------------------
  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,                // a + b
    ALU_SUB    = 4'd1,                // a - b
    ALU_SLL    = 4'd2,                // Logical left shift
    ALU_SLT    = 4'd3,                // Signed less-than
    ALU_SLTU   = 4'd4,                // Unsigned less-than
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,                // Logical right shift
    ALU_SRA    = 4'd7,                // Arithmetic right shift
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    ALU_PASS_B = 4'd10                // Operand b straight through, LUI
  } alu_op_e;

endpackage

//--- source/exec_if.sv
//--------------------------------------------------------------------------
// Decode to execute link
// Issued operation fields plus the combinational ALU result going back
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "core101_macros.svh"

interface exec_if
  import core101_pkg::*;
();

  logic                   valid;      // ID/EX holds a live operation
  alu_op_e                alu_op;     // Operation to perform
  logic [`XLEN-1:0]       operand_a;  // rs1 value or zero for LUI
  logic [`XLEN-1:0]       operand_b;  // rs2 value or immediate
  logic [`REG_ADDR_W-1:0] rd;         // Destination register
  logic [`XLEN-1:0]       result;     // Same-cycle ALU output

  // Decode side owns the ID/EX register and taps result for forwarding
  modport decode (
    output valid, alu_op, operand_a, operand_b, rd,
    input  result
  );

  // Execute side consumes the fields and returns the result
  modport exec (
    input  valid, alu_op, operand_a, operand_b, rd,
    output result
  );

endinterface

//--- source/fetch_unit.sv
//--------------------------------------------------------------------------
// Fetch stage
// Program counter and IF/ID register; halt holds the PC and issues bubbles
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "core101_macros.svh"

module fetch_unit (
  input  logic             clock,
  input  logic             reset,
  input  logic             halt,         // Freeze fetch this cycle
  output logic [`XLEN-1:0] instr_addr,   // To instruction memory
  input  logic [`XLEN-1:0] instr_data,   // Combinational read data
  output logic [`XLEN-1:0] instr,        // IF/ID instruction word
  output logic             instr_valid   // IF/ID holds a real fetch
);

  logic [`XLEN-1:0] pc;                  // Address being fetched

  assign instr_addr = pc;

  //------------------------------------------------------------------------
  // PC and IF/ID valid
  //------------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      pc          <= `RESET_PC;
      instr_valid <= 1'b0;
    end else if (halt) begin
      instr_valid <= 1'b0;               // PC holds, bubble goes down
    end else begin
      pc          <= pc + `PC_STEP;      // Sequential only, no branches
      instr_valid <= 1'b1;
    end
  end

  //------------------------------------------------------------------------
  // IF/ID instruction word
  //------------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (halt) begin
      instr <= `INSTR_NOP;               // Harmless ADDI x0 while frozen
    end else begin
      instr <= instr_data;               // Word at current PC
    end
  end

endmodule

//--- source/register_file.sv
//--------------------------------------------------------------------------
// General purpose register file
// 32 x XLEN, x0 hardwired to zero, two combinational reads with
// write-through from the writeback bus
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "core101_macros.svh"

module register_file (
  input  logic                   clock,
  input  logic                   reset,
  input  logic [`REG_ADDR_W-1:0] rs1_addr,
  input  logic [`REG_ADDR_W-1:0] rs2_addr,
  output logic [`XLEN-1:0]       rs1_data,
  output logic [`XLEN-1:0]       rs2_data,
  input  logic                   wb_valid,   // Write strobe from EX/WB
  input  logic [`REG_ADDR_W-1:0] wb_rd,
  input  logic [`XLEN-1:0]       wb_data
);

  logic [`XLEN-1:0] regs [`REG_COUNT];       // Entry 0 stays zero

  // One read port; same-cycle write is bypassed
  function automatic logic [`XLEN-1:0] read_port(
    input logic [`REG_ADDR_W-1:0] addr
  );
    logic [`XLEN-1:0] data;
    if (addr == '0) begin
      data = '0;                             // x0 always zero
    end else if (wb_valid && (wb_rd == addr)) begin
      data = wb_data;                        // Write-through
    end else begin
      data = regs[addr];
    end
    return data;
  endfunction

  always_comb begin
    rs1_data = read_port(rs1_addr);
    rs2_data = read_port(rs2_addr);
  end

  // Write at the edge closing the wb_valid cycle
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_valid && (wb_rd != '0)) begin
      regs[wb_rd] <= wb_data;                // x0 never written
    end
  end

endmodule

//--- source/decode_unit.sv
//--------------------------------------------------------------------------
// Decode and issue stage
// Field split, ALU op mapping, I/U immediates, EX forwarding, ID/EX
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "core101_macros.svh"

module decode_unit
  import core101_pkg::*;
(
  input  logic                   clock,
  input  logic                   reset,
  input  logic [`XLEN-1:0]       instr,        // From IF/ID
  input  logic                   instr_valid,
  output logic [`REG_ADDR_W-1:0] rs1_addr,     // To register file
  output logic [`REG_ADDR_W-1:0] rs2_addr,
  input  logic [`XLEN-1:0]       rs1_data,     // Already write-through
  input  logic [`XLEN-1:0]       rs2_data,
  exec_if.decode                 ex            // ID/EX fields out, result in
);

  opcode_e                opcode;
  logic [2:0]             funct3;
  logic [6:0]             funct7;
  logic [`REG_ADDR_W-1:0] rd;
  logic [`XLEN-1:0]       imm_i;               // Sign-extended I-type
  logic [`XLEN-1:0]       imm_u;               // U-type, low 12 zero
  logic [`XLEN-1:0]       src1;                // rs1 after forwarding
  logic [`XLEN-1:0]       src2;                // rs2 after forwarding
  alu_op_e                alu_op;
  logic                   use_imm;             // b from imm_i
  logic                   is_lui;              // b from imm_u, a zero
  logic                   supported;           // Known encoding

  // funct3 plus the funct7[5] alternate bit to ALU op
  function automatic alu_op_e funct_to_alu(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  //------------------------------------------------------------------------
  // Field extraction and immediates
  //------------------------------------------------------------------------
  assign opcode   = opcode_e'(instr[6:0]);
  assign rd       = instr[11:7];
  assign funct3   = instr[14:12];
  assign rs1_addr = instr[19:15];
  assign rs2_addr = instr[24:20];
  assign funct7   = instr[31:25];
  assign imm_i    = {{(`XLEN-12){instr[31]}}, instr[31:20]};
  assign imm_u    = {instr[31:12], 12'b0};

  // Previous op still in ID/EX is newer than anything in the GPRs
  assign src1 = (ex.valid && (ex.rd == rs1_addr) && (rs1_addr != '0)) ? ex.result : rs1_data;
  assign src2 = (ex.valid && (ex.rd == rs2_addr) && (rs2_addr != '0)) ? ex.result : rs2_data;

  //------------------------------------------------------------------------
  // Opcode decode
  //------------------------------------------------------------------------
  always_comb begin
    alu_op    = ALU_ADD;
    use_imm   = 1'b0;
    is_lui    = 1'b0;
    supported = 1'b0;
    case (opcode)
      OPC_OP: begin
        alu_op    = funct_to_alu(funct3, funct7[5]);
        supported = (funct7 == 7'b0000000) ||
                    ((funct7 == 7'b0100000) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
      end
      OPC_OP_IMM: begin
        use_imm = 1'b1;
        alu_op  = funct_to_alu(funct3, (funct3 == 3'b101) && funct7[5]); // Only SRAI alt
        if (funct3 == 3'b001) begin
          supported = (funct7 == 7'b0000000);                           // SLLI
        end else if (funct3 == 3'b101) begin
          supported = (funct7 == 7'b0000000) || (funct7 == 7'b0100000); // SRLI, SRAI
        end else begin
          supported = 1'b1;
        end
      end
      OPC_LUI: begin
        alu_op    = ALU_PASS_B;
        is_lui    = 1'b1;
        supported = 1'b1;
      end
      default: ;                                // Becomes a bubble
    endcase
  end

  //------------------------------------------------------------------------
  // ID/EX register
  //------------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      ex.valid <= 1'b0;
    end else begin
      ex.valid <= instr_valid && supported && (rd != '0); // x0 writes dropped
    end
  end

  always_ff @(posedge clock) begin
    ex.alu_op    <= alu_op;
    ex.operand_a <= is_lui ? '0 : src1;
    ex.operand_b <= is_lui ? imm_u : (use_imm ? imm_i : src2);
    ex.rd        <= rd;
  end

endmodule

//--- source/int_exec.sv
//--------------------------------------------------------------------------
// Integer execute stage
// RV32I ALU on the issued operands and the EX/WB writeback register
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "core101_macros.svh"

module int_exec
  import core101_pkg::*;
(
  input  logic                   clock,
  input  logic                   reset,
  exec_if.exec                   ex,          // From ID/EX
  output logic                   wb_valid,    // Writeback bus
  output logic [`REG_ADDR_W-1:0] wb_rd,
  output logic [`XLEN-1:0]       wb_data
);

  logic [`XLEN-1:0] a;
  logic [`XLEN-1:0] b;
  logic [4:0]       shamt;                     // Low five bits of b
  logic             lt_signed;
  logic             lt_unsigned;

  assign a           = ex.operand_a;
  assign b           = ex.operand_b;
  assign shamt       = b[4:0];
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  //------------------------------------------------------------------------
  // ALU, feeds forwarding in decode the same cycle
  //------------------------------------------------------------------------
  always_comb begin
    case (ex.alu_op)
      ALU_ADD:    ex.result = a + b;
      ALU_SUB:    ex.result = a - b;                          // Wraps on underflow
      ALU_SLL:    ex.result = a << shamt;
      ALU_SLT:    ex.result = {{(`XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU:   ex.result = {{(`XLEN-1){1'b0}}, lt_unsigned};
      ALU_XOR:    ex.result = a ^ b;
      ALU_SRL:    ex.result = a >> shamt;
      ALU_SRA:    ex.result = $signed(a) >>> shamt;           // Sign fill
      ALU_OR:     ex.result = a | b;
      ALU_AND:    ex.result = a & b;
      ALU_PASS_B: ex.result = b;                              // LUI
      default:    ex.result = '0;
    endcase
  end

  //------------------------------------------------------------------------
  // EX/WB register
  //------------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= ex.valid;
    end
  end

  always_ff @(posedge clock) begin
    wb_rd   <= ex.rd;
    wb_data <= ex.result;
  end

endmodule

//--- source/core101_top.sv
//--------------------------------------------------------------------------
// core101 top level
// Three-stage RV32I integer pipeline: fetch, decode/issue, execute
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "core101_macros.svh"

module core101_top (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   halt,        // Freezes fetch
  output logic [`XLEN-1:0]       instr_addr,  // Instruction port
  input  logic [`XLEN-1:0]       instr_data,
  output logic                   wb_valid,    // Retired result
  output logic [`REG_ADDR_W-1:0] wb_rd,
  output logic [`XLEN-1:0]       wb_data
);

  logic [`XLEN-1:0]       instr;              // IF/ID
  logic                   instr_valid;
  logic [`REG_ADDR_W-1:0] rs1_addr;           // Decode to GPR
  logic [`REG_ADDR_W-1:0] rs2_addr;
  logic [`XLEN-1:0]       rs1_data;           // GPR to decode
  logic [`XLEN-1:0]       rs2_data;

  exec_if ex_bus ();                          // ID/EX fields and result

  fetch_unit fetch_unit_inst (
    .clock       (clock),
    .reset       (reset),
    .halt        (halt),
    .instr_addr  (instr_addr),
    .instr_data  (instr_data),
    .instr       (instr),
    .instr_valid (instr_valid)
  );

  register_file register_file_inst (
    .clock    (clock),
    .reset    (reset),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb_valid (wb_valid),                     // Writeback loops back here
    .wb_rd    (wb_rd),
    .wb_data  (wb_data)
  );

  decode_unit decode_unit_inst (
    .clock       (clock),
    .reset       (reset),
    .instr       (instr),
    .instr_valid (instr_valid),
    .rs1_addr    (rs1_addr),
    .rs2_addr    (rs2_addr),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .ex          (ex_bus.decode)
  );

  int_exec int_exec_inst (
    .clock    (clock),
    .reset    (reset),
    .ex       (ex_bus.exec),
    .wb_valid (wb_valid),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data)
  );

endmodule

//--- bench/core101_tb.sv
//--------------------------------------------------------------------------
// core101 testbench
// Table-driven program in an instruction memory model, writeback checker
// against the table's expected results, fixed and random halt phases
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "core101_macros.svh"

module core101_tb;

  localparam int          NUM_ENTRIES = 32;          // Program length in words
  localparam logic [31:0] LFSR_SEED   = 32'h739d2417;
  localparam logic [6:0]  OPC_OP      = 7'b0110011;  // RV32I major opcodes
  localparam logic [6:0]  OPC_OPI     = 7'b0010011;
  localparam logic [6:0]  OPC_LOAD    = 7'b0000011;  // Not supported by the DUT

  logic                   clock;
  logic                   reset;
  logic                   halt;
  logic [`XLEN-1:0]       instr_addr;
  logic [`XLEN-1:0]       instr_data;
  logic                   wb_valid;
  logic [`REG_ADDR_W-1:0] wb_rd;
  logic [`XLEN-1:0]       wb_data;

  logic [31:0] table_instr [NUM_ENTRIES];            // Instruction word
  logic        table_wb    [NUM_ENTRIES];            // Writeback expected
  logic [4:0]  table_rd    [NUM_ENTRIES];
  logic [31:0] table_data  [NUM_ENTRIES];
  int          entry_count;
  logic [36:0] expected_q [$];                       // {rd, data} in order
  logic [36:0] head;
  logic [31:0] word_index;
  logic [31:0] expected_addr;                        // PC model from halt history
  logic [31:0] lfsr_state;
  logic        random_halt;                          // Halt from LFSR
  int          wb_count;
  int          expected_count;
  int          check_count;
  int          error_count;

  core101_top core101_top_inst (
    .clock      (clock),
    .reset      (reset),
    .halt       (halt),
    .instr_addr (instr_addr),
    .instr_data (instr_data),
    .wb_valid   (wb_valid),
    .wb_rd      (wb_rd),
    .wb_data    (wb_data)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;                      // 40 ns period
  end

  // Instruction memory with a combinational read
  always_comb begin
    word_index = instr_addr / `PC_STEP;
    if (word_index < NUM_ENTRIES) begin
      instr_data = table_instr[word_index[4:0]];
    end else begin
      instr_data = `INSTR_NOP;                       // Past the program
    end
  end

  //------------------------------------------------------------------------
  // Encoders and helpers
  //------------------------------------------------------------------------
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] lui(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, 7'b0110111};
  endfunction

  // Galois LFSR for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic [31:0] next;
    next = state >> 1;
    if (state[0]) begin
      next = next ^ 32'h8020_0003;
    end
    return next;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[ERROR] %0t: %s got 0x%08h, expected 0x%08h", $time, name, actual, expected);
    end
  endtask

  task automatic add_entry(input logic [31:0] word, input logic wb,
                           input logic [4:0] rd, input logic [31:0] data);
    table_instr[entry_count] = word;
    table_wb[entry_count]    = wb;
    table_rd[entry_count]    = rd;
    table_data[entry_count]  = data;
    entry_count++;
  endtask

  //------------------------------------------------------------------------
  // Program table with expected writebacks
  //------------------------------------------------------------------------
  task automatic build_table();
    entry_count = 0;
    add_entry(i_type(12'd5, 0, 3'b000, 1, OPC_OPI), 1, 1, 32'h0000_0005);   // ADDI
    add_entry(i_type(12'hFFD, 0, 3'b000, 2, OPC_OPI), 1, 2, 32'hFFFF_FFFD); // Neg imm
    add_entry(r_type(7'h00, 2, 1, 3'b000, 3), 1, 3, 32'h0000_0002);   // ADD at dist 1 and 2
    add_entry(r_type(7'h20, 1, 0, 3'b000, 4), 1, 4, 32'hFFFF_FFFB);   // SUB underflow
    add_entry(r_type(7'h00, 1, 2, 3'b010, 5), 1, 5, 32'h0000_0001);   // SLT -3 < 5
    add_entry(r_type(7'h00, 1, 2, 3'b011, 6), 1, 6, 32'h0000_0000);   // SLTU same pair
    add_entry(r_type(7'h20, 1, 2, 3'b101, 7), 1, 7, 32'hFFFF_FFFF);   // SRA
    add_entry(r_type(7'h00, 1, 2, 3'b101, 8), 1, 8, 32'h07FF_FFFF);   // SRL
    add_entry(r_type(7'h00, 1, 1, 3'b001, 9), 1, 9, 32'h0000_00A0);   // SLL
    add_entry(r_type(7'h00, 2, 1, 3'b100, 10), 1, 10, 32'hFFFF_FFF8); // XOR
    add_entry(r_type(7'h00, 2, 1, 3'b110, 11), 1, 11, 32'hFFFF_FFFD); // OR
    add_entry(r_type(7'h00, 2, 1, 3'b111, 12), 1, 12, 32'h0000_0005); // AND
    add_entry(lui(20'h12345, 13), 1, 13, 32'h1234_5000);
    add_entry(i_type(12'h678, 13, 3'b110, 13, OPC_OPI), 1, 13, 32'h1234_5678); // ORI
    add_entry(i_type(12'hFFF, 13, 3'b100, 14, OPC_OPI), 1, 14, 32'hEDCB_A987); // XORI -1
    add_entry(i_type(12'h0F0, 14, 3'b111, 15, OPC_OPI), 1, 15, 32'h0000_0080); // ANDI
    add_entry(i_type(12'hFFE, 2, 3'b010, 16, OPC_OPI), 1, 16, 32'h0000_0001);  // SLTI
    add_entry(i_type(12'hFFF, 1, 3'b011, 17, OPC_OPI), 1, 17, 32'h0000_0001);  // SLTIU
    add_entry(i_type(12'h003, 1, 3'b001, 18, OPC_OPI), 1, 18, 32'h0000_0028);  // SLLI
    add_entry(i_type(12'h004, 14, 3'b101, 19, OPC_OPI), 1, 19, 32'h0EDC_BA98); // SRLI
    add_entry(i_type(12'h404, 14, 3'b101, 20, OPC_OPI), 1, 20, 32'hFEDC_BA98); // SRAI
    add_entry(i_type(12'd7, 1, 3'b000, 0, OPC_OPI), 0, 0, 32'h0);     // x0 write dropped
    add_entry(r_type(7'h00, 1, 0, 3'b000, 21), 1, 21, 32'h0000_0005); // x0 still zero
    add_entry(i_type(12'd0, 0, 3'b010, 22, OPC_LOAD), 0, 0, 32'h0);   // LW becomes a bubble
    add_entry(32'hFFFF_FFFF, 0, 0, 32'h0);                           // Unknown opcode
    add_entry(r_type(7'h00, 21, 21, 3'b000, 24), 1, 24, 32'h0000_000A);
    add_entry(i_type(12'd1, 24, 3'b000, 25, OPC_OPI), 1, 25, 32'h0000_000B);
    add_entry(i_type(12'd1, 25, 3'b000, 25, OPC_OPI), 1, 25, 32'h0000_000C);
    add_entry(r_type(7'h00, 24, 25, 3'b000, 26), 1, 26, 32'h0000_0016); // Dist 1 and 3
    add_entry(r_type(7'h20, 24, 1, 3'b000, 27), 1, 27, 32'hFFFF_FFFB);  // 5 - 10
    add_entry(r_type(7'h00, 2, 1, 3'b010, 28), 1, 28, 32'h0000_0000);   // SLT 5 < -3
    add_entry(r_type(7'h00, 2, 1, 3'b011, 29), 1, 29, 32'h0000_0001);   // SLTU
  endtask

  // Steps to the next falling edge, checks the fetch address and drives halt
  task automatic next_cycle();
    @(negedge clock);
    if (!halt) begin
      expected_addr = expected_addr + `PC_STEP;    // PC stepped at the edge just passed
    end
    check_value("instr_addr", instr_addr, expected_addr);
    if (random_halt) begin
      halt       = lfsr_state[0];
      lfsr_state = lfsr_step(lfsr_state);
    end else begin
      halt = 1'b0;
    end
  endtask

  //------------------------------------------------------------------------
  // Writeback monitor
  //------------------------------------------------------------------------
  always @(negedge clock) begin
    if (wb_valid === 1'b1) begin
      wb_count++;
      if (expected_q.size() == 0) begin
        error_count++;
        $display("Unexpected writeback to x%0d at %0t", wb_rd, $time);
      end else begin
        head = expected_q.pop_front();
        check_value("wb_rd", wb_rd, head[36:32]);
        check_value("wb_data", wb_data, head[31:0]);
      end
    end
  end

  // Reset, latency check, then run the table to completion
  task automatic run_program(input logic use_random, output logic timed_out);
    int cycles;
    timed_out      = 1'b0;
    reset          = 1'b1;
    halt           = 1'b0;
    random_halt    = 1'b0;
    wb_count       = 0;
    expected_count = 0;
    expected_q.delete();
    for (int i = 0; i < entry_count; i++) begin
      if (table_wb[i]) begin
        expected_q.push_back({table_rd[i], table_data[i]});
        expected_count++;
      end
    end
    repeat (5) @(posedge clock);                    // Reset for 5 cycles
    @(negedge clock);
    reset         = 1'b0;
    expected_addr = `RESET_PC;
    check_value("instr_addr", instr_addr, `RESET_PC);
    check_value("wb_valid", wb_valid, 32'd0);
    cycles = 0;
    while ((wb_valid !== 1'b1) && (cycles < 10)) begin
      next_cycle();
      cycles++;
    end
    if (wb_valid !== 1'b1) begin
      error_count++;
      timed_out = 1'b1;
      $display("Timeout: no writeback within 10 cycles after reset");
    end else begin
      check_value("first result latency", cycles, 32'd3);
      random_halt = use_random;
      cycles      = 0;
      while ((expected_q.size() != 0) && (cycles < 2000)) begin
        next_cycle();
        cycles++;
      end
      if (expected_q.size() != 0) begin
        error_count++;
        timed_out = 1'b1;
        $display("Timeout: %0d expected writebacks never arrived", expected_q.size());
      end else begin
        random_halt = 1'b0;
        repeat (20) next_cycle();                   // Catch late extra results
        check_value("writeback count", wb_count, expected_count);
      end
    end
  endtask

  initial begin
    logic timed_out;
    reset       = 1'b1;
    halt        = 1'b0;
    random_halt = 1'b0;
    lfsr_state  = LFSR_SEED;
    check_count = 0;
    error_count = 0;
    build_table();
    run_program(1'b0, timed_out);                   // Halt held low throughout
    if (!timed_out) begin
      run_program(1'b1, timed_out);                 // Random halt cycles
    end
    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- core101.f
+incdir+source
source/core101_pkg.sv
source/exec_if.sv
source/fetch_unit.sv
source/register_file.sv
source/decode_unit.sv
source/int_exec.sv
source/core101_top.sv
bench/core101_tb.sv
